// File: audio_mixer.f
+incdir+verification
rtl/mixer_pkg.sv
rtl/sample_ringbuf.sv
rtl/mix_sequencer.sv
rtl/volume_multiplier.sv
rtl/mix_accumulator.sv
rtl/audio_mixer.sv
verification/audio_mixer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and decide pass or fail from its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module audio_mixer_tb \
    -f audio_mixer.f -o audio_mixer_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/audio_mixer_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verification/mixer_model.svh
// queue model of the mixer, meant to be included inside the testbench module after the mixer_pkg import
`ifndef MIXER_MODEL_SVH
`define MIXER_MODEL_SVH

localparam longint SAMPLE_MAX = (longint'(1) <<< (SAMPLE_W - 1)) - 1;
localparam longint SAMPLE_MIN = -(longint'(1) <<< (SAMPLE_W - 1));

logic [31:0] lfsr_state = 32'h1e82a8e8;
sample_t     ring_model [NUM_CH_IN][$];  // expected buffer contents, head first

// galois form, taps 32 31 29 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
endfunction

function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};  // one step per bit
    end
    return v;
endfunction

// signed value of the given width, sign extended to a sample
function automatic sample_t random_sample(input int bits);
    logic signed [31:0] r;
    r = $signed(next_bits(bits) << (32 - bits));
    return sample_t'(r >>> (32 - bits));
endfunction

function automatic longint clamp24(input longint x);
    if (x > SAMPLE_MAX) return SAMPLE_MAX;
    if (x < SAMPLE_MIN) return SAMPLE_MIN;
    return x;
endfunction

// inputs k, k+2, k+4, k+6 feed output k
function automatic in_mask_t group_mask(input int k);
    in_mask_t m;
    m = '0;
    for (int j = 0; j < CH_PER_OUT; j++) begin
        m[k + j * NUM_CH_OUT] = 1'b1;
    end
    return m;
endfunction

function automatic sample_t head_sample(input int i);
    if (ring_model[i].size() == 0) return '0;  // empty reads zero
    return ring_model[i][0];
endfunction

task automatic push_sample(input int i, input sample_t s);
    if (ring_model[i].size() < RB_DEPTH) begin
        ring_model[i].push_back(s);
    end  // full buffer drops the write
endtask

task automatic flush_queue(input int i);
    ring_model[i].delete();
endtask

task automatic pop_group(input int k);
    int idx;
    for (int j = 0; j < CH_PER_OUT; j++) begin
        idx = k + j * NUM_CH_OUT;
        if (ring_model[idx].size() > 0) void'(ring_model[idx].pop_front());
    end
endtask

// product is sample times gain shifted down by the fraction bits, clamped, then summed in order
function automatic sample_t expected_mix(input int k, input volume_t [NUM_CH_IN-1:0] gains);
    longint sum;
    longint prod;
    int     idx;
    sum = 0;
    for (int j = 0; j < CH_PER_OUT; j++) begin
        idx  = k + j * NUM_CH_OUT;
        prod = (longint'(head_sample(idx)) * longint'(gains[idx])) >>> VOL_FRAC;
        sum  = clamp24(sum + clamp24(prod));  // every add saturates
    end
    return sample_t'(sum);
endfunction

`endif

// File: verification/audio_mixer_tb.sv
// self-checking testbench; inputs and volumes only change while no output request is open
`timescale 1ns/10ps

module audio_mixer_tb import mixer_pkg::*; ();

    localparam int NUM_TESTS  = 6;
    localparam int MAX_REQS   = 8;              // most requests in one test
    localparam int ACK_LIMIT  = 3 * TIMESLICE;  // pop landing just as its own slice opens
    localparam int REQ_BUDGET = ACK_LIMIT + 4 * TIMESLICE + 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_REQS * REQ_BUDGET + 200;

    logic                    clk;
    logic                    rst;
    in_mask_t                rst_ch;
    in_mask_t                ack_in;
    sample_t [NUM_CH_IN-1:0] data_in;
    volume_t [NUM_CH_IN-1:0] vol;
    in_mask_t                pop_out;
    out_mask_t               pop_req;
    sample_t                 data_out;
    out_mask_t               ack_out;

    out_mask_t pending;  // requests still waiting for ack_o
    string     cur_test;
    int        test_errors;
    int        tests_failed;
    int        total_errors;
    int        total_checks;

    `include "mixer_model.svh"

    audio_mixer audio_mixer_inst (
        .clk      (clk),
        .rst      (rst),
        .rst_ch_i (rst_ch),
        .ack_i    (ack_in),
        .data_i   (data_in),
        .vol_i    (vol),
        .pop_o    (pop_out),
        .pop_i    (pop_req),
        .data_o   (data_out),
        .ack_o    (ack_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired, run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // next falling edge, then the checks that hold on every cycle
    task automatic step_cycle();
        in_mask_t exp_pop;
        @(negedge clk);
        exp_pop = '0;
        for (int k = 0; k < NUM_CH_OUT; k++) begin
            if (ack_out[k]) exp_pop = exp_pop | group_mask(k);
        end
        if ((ack_out & ~pending) != '0) begin
            $display("ERROR [%s]: ack_o %b arrived with no request pending", cur_test, ack_out);
            test_errors++;
        end
        if (pop_out !== exp_pop) begin
            $display("CHECK FAILED [%s]: pop_o expected %b actual %b", cur_test, exp_pop, pop_out);
            test_errors++;
        end
    endtask

    task automatic wait_idle(input int n);
        for (int c = 0; c < n; c++) step_cycle();
    endtask

    task automatic write_inputs(input in_mask_t mask, input sample_t [NUM_CH_IN-1:0] vals);
        step_cycle();
        ack_in  = mask;
        data_in = vals;
        for (int i = 0; i < NUM_CH_IN; i++) begin
            if (mask[i]) push_sample(i, vals[i]);
        end
        step_cycle();
        ack_in = '0;  // single strobe
    endtask

    task automatic load_random(input in_mask_t mask, input int bits);
        sample_t [NUM_CH_IN-1:0] vals;
        vals = '0;
        for (int i = 0; i < NUM_CH_IN; i++) begin
            if (mask[i]) vals[i] = random_sample(bits);
        end
        write_inputs(mask, vals);
    endtask

    task automatic set_volumes(input volume_t [NUM_CH_IN-1:0] gains);
        step_cycle();
        vol = gains;
    endtask

    task automatic clear_input(input int i);
        step_cycle();
        rst_ch = in_mask_t'(1) << i;
        flush_queue(i);
        step_cycle();
        rst_ch = '0;
    endtask

    // one pop_i pulse, then wait for the matching ack_o
    task automatic request_output(input int k);
        sample_t exp_data;
        logic    got;
        exp_data = expected_mix(k, vol);
        step_cycle();
        pop_req    = out_mask_t'(1) << k;
        pending[k] = 1'b1;
        got        = 1'b0;
        for (int c = 0; c < ACK_LIMIT && !got; c++) begin
            step_cycle();
            pop_req = '0;
            got     = ack_out[k];
        end
        pending[k] = 1'b0;
        total_checks++;
        if (!got) begin
            $display("ERROR [%s]: no ack_o[%0d] within %0d cycles", cur_test, k, ACK_LIMIT);
            test_errors++;
        end else begin
            if (data_out !== exp_data) begin
                $display("CHECK FAILED [%s]: data_o ch%0d expected %h actual %h",
                         cur_test, k, exp_data, data_out);
                test_errors++;
            end
            pop_group(k);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic report_result();
        if (test_errors == 0) begin
            $display("test %s: PASS", cur_test);
        end else begin
            $display("test %s: FAIL with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    task automatic unity_mix();
        volume_t [NUM_CH_IN-1:0] gains;
        start_test("unity_gain_mix");
        for (int i = 0; i < NUM_CH_IN; i++) gains[i] = 32'h0100_0000;
        set_volumes(gains);
        for (int r = 0; r < 3; r++) begin
            load_random('1, 12);
            request_output(0);
            request_output(1);
        end
        report_result();
    endtask

    task automatic random_volumes();
        volume_t [NUM_CH_IN-1:0] gains;
        start_test("random_volumes");
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < NUM_CH_IN; i++) gains[i] = next_bits(25);  // up to 2x
            set_volumes(gains);
            load_random('1, 24);
            request_output(0);
            request_output(1);
        end
        report_result();
    endtask

    task automatic saturation_limits();
        volume_t [NUM_CH_IN-1:0] gains;
        sample_t [NUM_CH_IN-1:0] vals;
        start_test("saturation");
        for (int i = 0; i < NUM_CH_IN; i++) gains[i] = 32'h0200_0000;
        set_volumes(gains);
        vals    = '0;
        vals[0] = 24'h7fffff;  // single product above full scale
        write_inputs(8'h01, vals);
        request_output(0);
        vals[1] = 24'h800000;
        write_inputs(8'h02, vals);
        request_output(1);
        for (int i = 0; i < NUM_CH_IN; i++) gains[i] = 32'h0100_0000;
        set_volumes(gains);
        for (int i = 0; i < NUM_CH_IN; i++) vals[i] = (i % 2 == 0) ? 24'h400000 : 24'hc00000;
        write_inputs('1, vals);  // sums overflow both ways
        request_output(0);
        request_output(1);
        vals[0] = 24'h700000;
        vals[2] = 24'h700000;
        vals[4] = 24'h900000;
        vals[6] = 24'h900000;
        write_inputs(8'h55, vals);  // clamp in the middle of the group
        request_output(0);
        report_result();
    endtask

    task automatic ring_rules();
        in_mask_t mask;
        start_test("ring_buffer_rules");
        for (int w = 0; w < RB_DEPTH + 1; w++) begin
            mask = 8'h01;
            if (w < 2) mask[2] = 1'b1;
            if (w < 1) mask[4] = 1'b1;
            load_random(mask, 20);
        end
        for (int r = 0; r < RB_DEPTH + 1; r++) request_output(0);  // last one sums zeros
        report_result();
    endtask

    task automatic channel_clear();
        start_test("per_channel_clear");
        load_random('1, 16);
        load_random('1, 16);
        clear_input(3);
        request_output(1);
        request_output(0);
        request_output(1);
        report_result();
    endtask

    task automatic request_latching();
        int k;
        int gap;
        start_test("request_latching");
        wait_idle(3 * TIMESLICE);  // nothing requested yet
        for (int r = 0; r < 6; r++) begin
            k   = int'(next_bits(1));
            gap = int'(next_bits(5));  // spreads the pop over slice phases
            load_random(group_mask(k), 16);
            wait_idle(gap);
            request_output(k);
            wait_idle(2 * TIMESLICE);  // a repeated ack would show here
        end
        report_result();
    endtask

    initial begin
        rst          = 1'b1;
        rst_ch       = '0;
        ack_in       = '0;
        data_in      = '0;
        vol          = '0;
        pop_req      = '0;
        pending      = '0;
        cur_test     = "reset";
        test_errors  = 0;
        tests_failed = 0;
        total_errors = 0;
        total_checks = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        unity_mix();
        random_volumes();
        saturation_limits();
        ring_rules();
        channel_clear();
        request_latching();

        $display("tests %0d, failed %0d, data checks %0d, errors %0d",
                 NUM_TESTS, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: rtl/audio_mixer.sv
// 8-in 2-out mixer at a fixed slice rate; no back-pressure, unrequested outputs are skipped
`timescale 1ns/10ps

module audio_mixer import mixer_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  in_mask_t                 rst_ch_i,  // per-input buffer flush
    input  in_mask_t                 ack_i,     // sample write strobes
    input  sample_t [NUM_CH_IN-1:0]  data_i,
    input  volume_t [NUM_CH_IN-1:0]  vol_i,     // 8.24 gains
    output in_mask_t                 pop_o,
    input  out_mask_t                pop_i,     // output requests
    output sample_t                  data_o,
    output out_mask_t                ack_o
);

    sample_t [NUM_CH_IN-1:0] head;  // ring buffer heads
    slot_t                   slot;
    product_t                product;

    // input ring buffers
    for (genvar i = 0; i < NUM_CH_IN; i++) begin : g_rb
        sample_ringbuf rb_inst (
            .clk    (clk),
            .rst    (rst),
            .clr_i  (rst_ch_i[i]),
            .wr_i   (ack_i[i]),
            .data_i (data_i[i]),
            .pop_i  (pop_o[i]),
            .head_o (head[i])
        );
    end

    mix_sequencer seq_inst (
        .clk    (clk),
        .rst    (rst),
        .pop_i  (pop_i),
        .slot_o (slot),
        .ack_o  (ack_o)
    );

    volume_multiplier mult_inst (
        .clk       (clk),
        .in_ch_i   (slot.in_ch),
        .samples_i (head),
        .vol_i     (vol_i),
        .product_o (product)
    );

    mix_accumulator acc_inst (
        .clk         (clk),
        .rst         (rst),
        .product_i   (product),
        .slice_end_i (slot.slice_end),
        .sum_o       (data_o)
    );

    // input i belongs to output i mod NUM_CH_OUT
    assign pop_o = {CH_PER_OUT{ack_o}};

endmodule

// File: rtl/mix_accumulator.sv
// clamps each product to 24 bits and sums one group per slice; every add saturates, no extra headroom
`timescale 1ns/10ps

module mix_accumulator import mixer_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  product_t product_i,
    input  logic     slice_end_i,
    output sample_t  sum_o
);

    sample_t               sat_q;   // clamped product
    sample_t               sum_q;   // running group sum
    logic [MULT_LATENCY:0] live_q;  // fill marker, bit 0 set once real products arrive

    logic prod_in_range;

    // 24-bit add that clamps instead of wrapping
    function automatic sample_t sat_add(sample_t a, sample_t b);
        logic [SAMPLE_W:0] s;
        s = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b};
        case (s[SAMPLE_W:SAMPLE_W-1])
            2'b01:   return SAT_MAX;  // positive overflow
            2'b10:   return SAT_MIN;  // negative overflow
            default: return s[SAMPLE_W-1:0];
        endcase
    endfunction

    // upper bits all equal means the product fits in a sample
    assign prod_in_range = (&product_i[PROD_W-1:SAMPLE_W-1]) |
                           ~(|product_i[PROD_W-1:SAMPLE_W-1]);

    always_ff @(posedge clk) begin
        if (prod_in_range) begin
            sat_q <= product_i[SAMPLE_W-1:0];
        end else begin
            sat_q <= product_i[PROD_W-1] ? SAT_MIN : SAT_MAX;
        end
    end

    // restart at slice end, ones march down until the first group product lands
    always_ff @(posedge clk) begin
        if (rst) begin
            live_q <= '0;
        end else if (slice_end_i) begin
            live_q <= '0;
        end else begin
            live_q <= {1'b1, live_q[MULT_LATENCY:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!live_q[0]) begin
            sum_q <= '0;  // pipeline still holds the previous group
        end else begin
            sum_q <= sat_add(sum_q, sat_q);
        end
    end

    // valid only in the slice end cycle
    assign sum_o = sum_q;

endmodule

// File: rtl/volume_multiplier.sv
// six-stage gain multiply; one operand per cycle, result is (sample * volume) >>> 24 without clamp
`timescale 1ns/10ps

module volume_multiplier import mixer_pkg::*; (
    input  logic                     clk,
    input  in_ch_t                   in_ch_i,
    input  sample_t [NUM_CH_IN-1:0]  samples_i,
    input  volume_t [NUM_CH_IN-1:0]  vol_i,
    output product_t                 product_o
);

    // full-precision product of signed sample and unsigned gain
    typedef logic signed [SAMPLE_W+VOL_W:0] wide_t;

    localparam int DLY_STAGES = MULT_LATENCY - 3;  // after select, multiply, rescale

    sample_t  sample_q;  // stage 1
    volume_t  vol_q;
    wide_t    mult_q;    // stage 2
    product_t scaled_q;  // stage 3
    product_t dly_q [DLY_STAGES];

    // operand select
    always_ff @(posedge clk) begin
        sample_q <= samples_i[in_ch_i];
        vol_q    <= vol_i[in_ch_i];
    end

    // gain is unsigned, so extend it with a zero sign bit
    always_ff @(posedge clk) begin
        mult_q <= wide_t'(sample_q) * wide_t'($signed({1'b0, vol_q}));
    end

    // drop the fraction bits, upper slice equals an arithmetic shift
    always_ff @(posedge clk) begin
        scaled_q <= mult_q[SAMPLE_W+VOL_W:VOL_FRAC];
    end

    // balance stages for retiming of the multiplier
    always_ff @(posedge clk) begin
        dly_q[0] <= scaled_q;
        for (int i = 1; i < DLY_STAGES; i++) begin
            dly_q[i] <= dly_q[i-1];
        end
    end

    assign product_o = dly_q[DLY_STAGES-1];

endmodule

// File: rtl/mix_sequencer.sv
// fixed 12-cycle slices per output; a request must be latched before its slice opens to be served
`timescale 1ns/10ps

module mix_sequencer import mixer_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  out_mask_t pop_i,
    output slot_t     slot_o,
    output out_mask_t ack_o
);

    slice_cnt_t cnt_q;     // position inside the slice
    in_ch_t     in_ch_q;   // input fed to the multiplier
    out_ch_t    out_ch_q;  // output being mixed
    out_mask_t  req_q;     // pending consumer requests
    logic       valid_q;   // current slice answers a request

    logic      slice_end;
    out_ch_t   out_ch_nxt;
    out_mask_t cur_mask;

    assign slice_end = (cnt_q == SLICE_LAST);
    assign cur_mask  = out_mask_t'(1) << out_ch_q;

    // next output channel, wrapping
    assign out_ch_nxt = (out_ch_q == out_ch_t'(NUM_CH_OUT - 1)) ? '0 : out_ch_q + 1'b1;

    // slice counter and channel indices
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q    <= '0;
            in_ch_q  <= '0;
            out_ch_q <= '0;
        end else if (slice_end) begin
            cnt_q    <= '0;
            out_ch_q <= out_ch_nxt;
            in_ch_q  <= in_ch_t'(out_ch_nxt);  // group starts at its output index
        end else begin
            cnt_q   <= cnt_q + 1'b1;
            in_ch_q <= in_ch_q + in_ch_t'(NUM_CH_OUT);  // stride across the group
        end
    end

    // request latches
    // taken and cleared as the slice opens, a late pop_i waits a full round
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q   <= '0;
            valid_q <= 1'b0;
        end else if (cnt_q == '0) begin
            valid_q <= req_q[out_ch_q];
            req_q   <= (req_q & ~cur_mask) | pop_i;  // new pop wins over clear
        end else begin
            req_q <= req_q | pop_i;
        end
    end

    // one pulse per served request, aligned with the finished sum
    assign ack_o = (slice_end && valid_q) ? cur_mask : '0;

    assign slot_o.in_ch     = in_ch_q;
    assign slot_o.slice_end = slice_end;

endmodule

// File: rtl/sample_ringbuf.sv
// 4-entry sample FIFO; empty head reads zero, writes while full are dropped unless popped
`timescale 1ns/10ps

module sample_ringbuf import mixer_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    clr_i,   // per-channel flush
    input  logic    wr_i,
    input  sample_t data_i,
    input  logic    pop_i,
    output sample_t head_o
);

    sample_t mem [RB_DEPTH];  // sample storage, no reset
    rb_ptr_t rd_ptr_q;
    rb_ptr_t wr_ptr_q;
    rb_cnt_t count_q;

    logic empty;
    logic full;
    logic do_pop;
    logic do_wr;

    assign empty  = (count_q == '0);
    assign full   = (count_q == rb_cnt_t'(RB_DEPTH));
    assign do_pop = pop_i & ~empty;
    assign do_wr  = wr_i & (~full | do_pop);  // full slot freed by same-cycle pop

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_wr, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // head visible without a read strobe
    assign head_o = empty ? '0 : mem[rd_ptr_q];

endmodule

// File: rtl/mixer_pkg.sv
// fixed mixer geometry of 8 inputs to 2 outputs; ring depth must stay a power of two
package mixer_pkg;

    // channel layout
    localparam int NUM_CH_IN  = 8;
    localparam int NUM_CH_OUT = 2;
    localparam int CH_PER_OUT = NUM_CH_IN / NUM_CH_OUT;  // inputs per output group

    // datapath widths
    localparam int SAMPLE_W = 24;
    localparam int VOL_W    = 32;
    localparam int VOL_FRAC = 24;  // 8.24 gain, unity is 0x0100_0000

    // rescaled product: signed sample times zero-extended volume, shifted down
    localparam int PROD_W = SAMPLE_W + VOL_W + 1 - VOL_FRAC;

    // slice timing
    localparam int MULT_LATENCY = 6;
    localparam int TIMESLICE    = CH_PER_OUT + MULT_LATENCY + 2;  // + saturate + sum
    localparam int SLICE_CNT_W  = $clog2(TIMESLICE);

    // input ring buffers
    localparam int RB_DEPTH = 4;
    localparam int RB_PTR_W = $clog2(RB_DEPTH);
    localparam int RB_CNT_W = $clog2(RB_DEPTH + 1);

    localparam int IN_CH_W  = $clog2(NUM_CH_IN);
    localparam int OUT_CH_W = (NUM_CH_OUT > 1) ? $clog2(NUM_CH_OUT) : 1;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic        [VOL_W-1:0]    volume_t;
    typedef logic signed [PROD_W-1:0]   product_t;

    typedef logic [NUM_CH_IN-1:0]  in_mask_t;
    typedef logic [NUM_CH_OUT-1:0] out_mask_t;

    typedef logic [IN_CH_W-1:0]     in_ch_t;
    typedef logic [OUT_CH_W-1:0]    out_ch_t;
    typedef logic [SLICE_CNT_W-1:0] slice_cnt_t;
    typedef logic [RB_PTR_W-1:0]    rb_ptr_t;
    typedef logic [RB_CNT_W-1:0]    rb_cnt_t;

    // last count of a slice
    localparam slice_cnt_t SLICE_LAST = slice_cnt_t'(TIMESLICE - 1);

    // clamp limits of a 24-bit sample
    localparam sample_t SAT_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};  // 0x7fffff
    localparam sample_t SAT_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};  // 0x800000

    // what the sequencer hands the datapath each cycle
    typedef struct packed {
        in_ch_t in_ch;      // input presented to the multiplier
        logic   slice_end;  // last cycle of the slice
    } slot_t;

endpackage
